// ==== hw/cop_macros.svh ====
// Word width, CPR count and instruction field position macros
`ifndef COP_MACROS_SVH
`define COP_MACROS_SVH

// --------------------------------------------------
// Data path sizes
// --------------------------------------------------
`define COP_XLEN        32      // Data word width
`define COP_NCPRS       16      // Number of CPRs

// --------------------------------------------------
// Instruction field low bits
// --------------------------------------------------
`define COP_OP_LSB      0       // op   [2:0]
`define COP_CRD_LSB     4       // crd  [7:4]
`define COP_CRS1_LSB    8       // crs1 [11:8]
`define COP_CRS2_LSB    12      // crs2 [15:12]
`define COP_GRD_LSB     16      // GPR destination [20:16]

`endif

// ==== hw/cop_isa_pkg.sv ====
// ISA package with word and index typedefs, operation and result enums
`include "cop_macros.svh"

package cop_isa_pkg;

    // --------------------------------------------------
    // Plain vectors
    // --------------------------------------------------
    typedef logic [`COP_XLEN-1:0]          cop_word_t;  // Data word
    typedef logic [31:0]                   cop_insn_t;  // Instruction encoding
    typedef logic [$clog2(`COP_NCPRS)-1:0] cpr_idx_t;   // CPR index
    typedef logic [4:0]                    gpr_idx_t;   // CPU GPR index

    // --------------------------------------------------
    // Operation codes, op field of the encoding
    // --------------------------------------------------
    // Codes 5 to 7 have no entry and decode as illegal
    typedef enum logic [2:0] {
        OP_MV2COP = 3'd0,   // crd <- rs1
        OP_MV2GPR = 3'd1,   // GPR <- crs1
        OP_ADD    = 3'd2,   // crd <- crs1 + crs2
        OP_XOR    = 3'd3,   // crd <- crs1 ^ crs2
        OP_ROTL   = 3'd4    // crd <- crs1 rotl crs2[4:0]
    } cop_op_t;

    // Result code returned with every response
    typedef enum logic [2:0] {
        RES_OK       = 3'd0,
        RES_ABORTED  = 3'd1,    // CPU aborted at request time
        RES_BAD_INSN = 3'd2     // Unknown op code
    } cop_result_t;

endpackage

// ==== hw/cop_trace_pkg.sv ====
// Trace package with CPR snapshot, transaction record and checker state enum
`include "cop_macros.svh"

package cop_trace_pkg;

    // Whole CPR file, entry i is CPR i
    typedef cop_isa_pkg::cop_word_t [`COP_NCPRS-1:0] cpr_snap_t;

    // --------------------------------------------------
    // One completed instruction as seen on the pins
    // --------------------------------------------------
    typedef struct packed {
        cop_isa_pkg::cop_insn_t   insn_enc;  // Encoding at accept
        cop_isa_pkg::cop_word_t   rs1;       // RS1 at accept
        logic                     aborted;   // abort_req at accept
        cpr_snap_t                pre;       // CPRs before execute
        cpr_snap_t                post;      // CPRs at completion
        cop_isa_pkg::cop_result_t result;
        logic                     wen;
        cop_isa_pkg::gpr_idx_t    waddr;
        cop_isa_pkg::cop_word_t   wdata;
    } cop_txn_t;

    // Checker state
    typedef enum logic {
        CHK_IDLE  = 1'b0,   // No record last cycle
        CHK_CHECK = 1'b1    // Record checked last cycle
    } chk_state_t;

endpackage

// ==== hw/cop_exec.sv ====
// Coprocessor core: request acceptance, decode, CPR file, execute, held response
`include "cop_macros.svh"

module cop_exec (
    input  logic                     g_clk,
    input  logic                     g_resetn,
    input  logic                     insn_req,   // CPU request, held until insn_ack
    input  logic                     abort_req,  // Abort this request
    input  cop_isa_pkg::cop_insn_t   insn_enc,
    input  cop_isa_pkg::cop_word_t   rs1,
    input  logic                     rsp_ack,    // CPU takes the response
    output logic                     insn_ack,
    output logic                     insn_rsp,
    output logic                     wen,        // GPR write back
    output cop_isa_pkg::gpr_idx_t    waddr,
    output cop_isa_pkg::cop_word_t   wdata,
    output cop_isa_pkg::cop_result_t result,
    output cop_trace_pkg::cpr_snap_t cprs        // CPR file for the trace path
);

    localparam int sh_w = $clog2(`COP_XLEN);    // Rotate amount bits

    typedef enum logic [1:0] {
        EX_IDLE    = 2'd0,
        EX_ACKED   = 2'd1,  // insn_ack high this cycle
        EX_RESPOND = 2'd2   // Response held for rsp_ack
    } ex_state_t;

    ex_state_t                state;
    cop_trace_pkg::cpr_snap_t cpr_q;            // CPR file

    // --------------------------------------------------
    // Decode
    // --------------------------------------------------
    cop_isa_pkg::cop_op_t     op;
    cop_isa_pkg::cpr_idx_t    crd;
    cop_isa_pkg::cpr_idx_t    crs1;
    cop_isa_pkg::cpr_idx_t    crs2;
    cop_isa_pkg::gpr_idx_t    grd;
    cop_isa_pkg::cop_word_t   src_a;
    cop_isa_pkg::cop_word_t   src_b;
    logic [2*`COP_XLEN-1:0]   rot_wide;
    cop_isa_pkg::cop_word_t   alu_res;
    logic                     legal;
    logic                     cpr_wr;
    logic                     gpr_wr;
    logic                     accept;

    assign op   = cop_isa_pkg::cop_op_t'(insn_enc[`COP_OP_LSB +: 3]);
    assign crd  = insn_enc[`COP_CRD_LSB  +: $bits(cop_isa_pkg::cpr_idx_t)];
    assign crs1 = insn_enc[`COP_CRS1_LSB +: $bits(cop_isa_pkg::cpr_idx_t)];
    assign crs2 = insn_enc[`COP_CRS2_LSB +: $bits(cop_isa_pkg::cpr_idx_t)];
    assign grd  = insn_enc[`COP_GRD_LSB  +: $bits(cop_isa_pkg::gpr_idx_t)];

    assign src_a = cpr_q[crs1];                 // Operand reads
    assign src_b = cpr_q[crs2];

    // Doubled word shifted left, top half is the rotate
    assign rot_wide = {src_a, src_a} << src_b[sh_w-1:0];

    assign accept = insn_req && insn_ack;       // Request taken on this edge

    // --------------------------------------------------
    // Execute
    // --------------------------------------------------
    always_comb begin
        alu_res = src_a;
        legal   = 1'b1;
        cpr_wr  = 1'b0;
        gpr_wr  = 1'b0;
        case (op)
            cop_isa_pkg::OP_MV2COP: begin
                alu_res = rs1;
                cpr_wr  = 1'b1;
            end
            cop_isa_pkg::OP_MV2GPR: gpr_wr = 1'b1;        // Read out crs1
            cop_isa_pkg::OP_ADD: begin
                alu_res = src_a + src_b;                  // Wraps mod 2^32
                cpr_wr  = 1'b1;
            end
            cop_isa_pkg::OP_XOR: begin
                alu_res = src_a ^ src_b;
                cpr_wr  = 1'b1;
            end
            cop_isa_pkg::OP_ROTL: begin
                alu_res = rot_wide[2*`COP_XLEN-1 -: `COP_XLEN];
                cpr_wr  = 1'b1;
            end
            default: legal = 1'b0;                        // Codes 5..7
        endcase
    end

    // Control FSM, result code and CPR writes
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state    <= EX_IDLE;
            insn_ack <= 1'b0;
            insn_rsp <= 1'b0;
            wen      <= 1'b0;
            result   <= cop_isa_pkg::RES_OK;
            cpr_q    <= '0;
        end else begin
            case (state)
                EX_IDLE: begin
                    if (insn_req) begin
                        insn_ack <= 1'b1;
                        state    <= EX_ACKED;
                    end
                end
                EX_ACKED: begin
                    insn_ack <= 1'b0;                     // Single cycle pulse
                    if (accept) begin
                        insn_rsp <= 1'b1;
                        state    <= EX_RESPOND;
                        if (abort_req) begin
                            result <= cop_isa_pkg::RES_ABORTED;
                            wen    <= 1'b0;
                        end else if (!legal) begin
                            result <= cop_isa_pkg::RES_BAD_INSN;
                            wen    <= 1'b0;
                        end else begin
                            result <= cop_isa_pkg::RES_OK;
                            wen    <= gpr_wr;
                            if (cpr_wr) begin
                                cpr_q[crd] <= alu_res;
                            end
                        end
                    end else begin
                        state <= EX_IDLE;                 // Request withdrawn
                    end
                end
                EX_RESPOND: begin
                    if (rsp_ack) begin
                        insn_rsp <= 1'b0;
                        state    <= EX_IDLE;
                    end
                end
                default: state <= EX_IDLE;
            endcase
        end
    end

    // Write back payload, held with insn_rsp
    always_ff @(posedge g_clk) begin
        if (accept) begin
            waddr <= grd;
            wdata <= src_a;
        end
    end

    assign cprs = cpr_q;

endmodule

// ==== hw/cop_trace_capture.sv ====
// Transaction capture: pre state at accept, post state and results at completion
module cop_trace_capture (
    input  logic                     g_clk,
    input  logic                     g_resetn,
    input  logic                     insn_req,
    input  logic                     insn_ack,
    input  logic                     abort_req,
    input  cop_isa_pkg::cop_insn_t   insn_enc,
    input  cop_isa_pkg::cop_word_t   rs1,
    input  logic                     insn_rsp,
    input  logic                     rsp_ack,
    input  logic                     wen,
    input  cop_isa_pkg::gpr_idx_t    waddr,
    input  cop_isa_pkg::cop_word_t   wdata,
    input  cop_isa_pkg::cop_result_t result,
    input  cop_trace_pkg::cpr_snap_t cprs,
    output logic                     txn_valid,  // One cycle per completed record
    output cop_trace_pkg::cop_txn_t  txn
);

    logic                     accept;
    logic                     complete;
    logic                     pend_q;           // Pre state held, response due
    cop_isa_pkg::cop_insn_t   pend_enc;
    cop_isa_pkg::cop_word_t   pend_rs1;
    logic                     pend_abort;
    cop_trace_pkg::cpr_snap_t pend_pre;

    assign accept   = insn_req && insn_ack;
    assign complete = insn_rsp && rsp_ack;

    // --------------------------------------------------
    // Pending pre-instruction state
    // --------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (accept) begin
            pend_enc   <= insn_enc;
            pend_rs1   <= rs1;
            pend_abort <= abort_req;
            pend_pre   <= cprs;                 // CPRs before the write
        end
    end

    // Record only responses that had a captured request
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pend_q    <= 1'b0;
            txn_valid <= 1'b0;
        end else begin
            txn_valid <= complete && pend_q;
            if (accept) begin
                pend_q <= 1'b1;
            end else if (complete) begin
                pend_q <= 1'b0;
            end
        end
    end

    // --------------------------------------------------
    // Completed record
    // --------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (complete) begin
            txn.insn_enc <= pend_enc;
            txn.rs1      <= pend_rs1;
            txn.aborted  <= pend_abort;
            txn.pre      <= pend_pre;
            txn.post     <= cprs;               // Written at execute
            txn.result   <= result;
            txn.wen      <= wen;
            txn.waddr    <= waddr;
            txn.wdata    <= wdata;
        end
    end

endmodule

// ==== hw/cop_trace_checker.sv ====
// Trace checker: recomputes each record, sticky error flag and checked count
`include "cop_macros.svh"

module cop_trace_checker (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    input  logic                    txn_valid,
    input  cop_trace_pkg::cop_txn_t txn,
    output logic                    chk_error,  // Sticky until reset
    output cop_isa_pkg::cop_word_t  chk_count   // Records checked
);

    localparam int sh_w = $clog2(`COP_XLEN);

    cop_trace_pkg::chk_state_t state;

    cop_isa_pkg::cop_op_t     op;
    cop_isa_pkg::cpr_idx_t    crd;
    cop_isa_pkg::gpr_idx_t    grd;
    cop_isa_pkg::cop_word_t   a;
    cop_isa_pkg::cop_word_t   b;
    cop_trace_pkg::cpr_snap_t exp_post;
    logic                     exp_wen;
    cop_isa_pkg::cop_result_t exp_result;
    logic                     mismatch;

    // Rotate as two shifts, zero amount kept apart
    function automatic cop_isa_pkg::cop_word_t rotl(
        input cop_isa_pkg::cop_word_t v,
        input logic [sh_w-1:0]        n
    );
        if (n == '0) begin
            return v;
        end
        return (v << n) | (v >> (`COP_XLEN - n));
    endfunction

    // --------------------------------------------------
    // Recompute from the pre snapshot
    // --------------------------------------------------
    assign op  = cop_isa_pkg::cop_op_t'(txn.insn_enc[`COP_OP_LSB +: 3]);
    assign crd = txn.insn_enc[`COP_CRD_LSB +: $bits(cop_isa_pkg::cpr_idx_t)];
    assign grd = txn.insn_enc[`COP_GRD_LSB +: $bits(cop_isa_pkg::gpr_idx_t)];
    assign a   = txn.pre[txn.insn_enc[`COP_CRS1_LSB +: $bits(cop_isa_pkg::cpr_idx_t)]];
    assign b   = txn.pre[txn.insn_enc[`COP_CRS2_LSB +: $bits(cop_isa_pkg::cpr_idx_t)]];

    always_comb begin
        exp_post   = txn.pre;                   // Untouched unless written
        exp_wen    = 1'b0;
        exp_result = cop_isa_pkg::RES_OK;
        if (txn.aborted) begin
            exp_result = cop_isa_pkg::RES_ABORTED;
        end else begin
            case (op)
                cop_isa_pkg::OP_MV2COP: exp_post[crd] = txn.rs1;
                cop_isa_pkg::OP_MV2GPR: exp_wen       = 1'b1;
                cop_isa_pkg::OP_ADD:    exp_post[crd] = a + b;
                cop_isa_pkg::OP_XOR:    exp_post[crd] = a ^ b;
                cop_isa_pkg::OP_ROTL:   exp_post[crd] = rotl(a, b[sh_w-1:0]);
                default:                exp_result    = cop_isa_pkg::RES_BAD_INSN;
            endcase
        end
        // All CPRs, flags and result; write back payload only when used
        mismatch = (txn.post != exp_post) || (txn.wen != exp_wen) ||
                   (txn.result != exp_result) ||
                   (exp_wen && ((txn.waddr != grd) || (txn.wdata != a)));
    end

    // --------------------------------------------------
    // Error flag and count
    // --------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state     <= cop_trace_pkg::CHK_IDLE;
            chk_error <= 1'b0;
            chk_count <= '0;
        end else if (txn_valid) begin
            state     <= cop_trace_pkg::CHK_CHECK;
            chk_count <= chk_count + 1'b1;
            // Back to back records cannot come from a real completion
            if (mismatch || (state == cop_trace_pkg::CHK_CHECK)) begin
                chk_error <= 1'b1;
            end
        end else begin
            state <= cop_trace_pkg::CHK_IDLE;
        end
    end

endmodule

// ==== hw/cop_checked_top.sv ====
// Top level with coprocessor core, trace capture and trace checker
module cop_checked_top (
    input  logic                     g_clk,
    input  logic                     g_resetn,
    input  logic                     insn_req,
    input  logic                     abort_req,
    input  cop_isa_pkg::cop_insn_t   insn_enc,
    input  cop_isa_pkg::cop_word_t   rs1,
    input  logic                     rsp_ack,
    output logic                     insn_ack,
    output logic                     insn_rsp,
    output logic                     wen,
    output cop_isa_pkg::gpr_idx_t    waddr,
    output cop_isa_pkg::cop_word_t   wdata,
    output cop_isa_pkg::cop_result_t result,
    output logic                     chk_error,
    output cop_isa_pkg::cop_word_t   chk_count
);

    cop_trace_pkg::cpr_snap_t cprs;         // Live CPR file
    logic                     txn_valid;
    cop_trace_pkg::cop_txn_t  txn;

    // --------------------------------------------------
    // Producer, buffer, consumer
    // --------------------------------------------------
    cop_exec u_exec (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .insn_req  (insn_req),
        .abort_req (abort_req),
        .insn_enc  (insn_enc),
        .rs1       (rs1),
        .rsp_ack   (rsp_ack),
        .insn_ack  (insn_ack),
        .insn_rsp  (insn_rsp),
        .wen       (wen),
        .waddr     (waddr),
        .wdata     (wdata),
        .result    (result),
        .cprs      (cprs)
    );

    cop_trace_capture u_capture (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .insn_req  (insn_req),
        .insn_ack  (insn_ack),
        .abort_req (abort_req),
        .insn_enc  (insn_enc),
        .rs1       (rs1),
        .insn_rsp  (insn_rsp),
        .rsp_ack   (rsp_ack),
        .wen       (wen),
        .waddr     (waddr),
        .wdata     (wdata),
        .result    (result),
        .cprs      (cprs),
        .txn_valid (txn_valid),
        .txn       (txn)
    );

    cop_trace_checker u_checker (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .txn_valid (txn_valid),
        .txn       (txn),
        .chk_error (chk_error),
        .chk_count (chk_count)
    );

endmodule

// ==== test/cop_asserts.sv ====
// Handshake assertions for the coprocessor core and their bind to cop_exec
module cop_asserts (
    input logic g_clk,
    input logic g_resetn,
    input logic insn_ack,
    input logic insn_rsp,
    input logic rsp_ack
);
    timeunit 1ns;
    timeprecision 1ps;

    // --------------------------------------------------
    // Request side
    // --------------------------------------------------
    ack_single_pulse: assert property (@(posedge g_clk) disable iff (!g_resetn)
        insn_ack |=> !insn_ack)
        else $error("insn_ack high for more than one cycle");

    // Core stays busy while a response is out
    ack_not_during_rsp: assert property (@(posedge g_clk) disable iff (!g_resetn)
        insn_rsp |-> !insn_ack)
        else $error("insn_ack raised with insn_rsp high");

    // --------------------------------------------------
    // Response side
    // --------------------------------------------------
    rsp_held_until_ack: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (insn_rsp && !rsp_ack) |=> insn_rsp)
        else $error("insn_rsp dropped before rsp_ack");

endmodule

bind cop_exec cop_asserts u_asserts (
    .g_clk    (g_clk),
    .g_resetn (g_resetn),
    .insn_ack (insn_ack),
    .insn_rsp (insn_rsp),
    .rsp_ack  (rsp_ack)
);

// ==== test/tb_cop.sv ====
// Checked coprocessor testbench with clock, reset, LCG stimulus, CPR model, checks and watchdog
`include "cop_macros.svh"

module tb_cop;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          n_tests      = 300;
    localparam logic [31:0] seed         = 32'h98938ea9;
    localparam logic [31:0] abort_pct    = 32'd12;     // Roughly 1 in 8
    localparam int          reset_cycles = 10;
    localparam int          test_cycles  = 10;         // Bound per instruction
    localparam int          idx_w        = $bits(cop_isa_pkg::cpr_idx_t);
    localparam int          watchdog_ns  = (n_tests + `COP_NCPRS + reset_cycles) * test_cycles * 10;

    logic                     g_clk;
    logic                     g_resetn;
    logic                     insn_req;
    logic                     abort_req;
    cop_isa_pkg::cop_insn_t   insn_enc;
    cop_isa_pkg::cop_word_t   rs1;
    logic                     rsp_ack;
    logic                     insn_ack;
    logic                     insn_rsp;
    logic                     wen;
    cop_isa_pkg::gpr_idx_t    waddr;
    cop_isa_pkg::cop_word_t   wdata;
    cop_isa_pkg::cop_result_t result;
    logic                     chk_error;
    cop_isa_pkg::cop_word_t   chk_count;

    logic [31:0]              rng_state;
    cop_isa_pkg::cop_word_t   model_cprs [`COP_NCPRS];  // Reference CPR file
    int                       done_count;               // Completed instructions

    cop_checked_top UUT (.*);

    initial begin
        g_clk = 1'b0;
        forever #5 g_clk = ~g_clk;
    end

    // --------------------------------------------------
    // Failure reporting and compares
    // --------------------------------------------------
    task automatic stop_run();
        $display("ERRORS FOUND");
        $fatal(1, "Run stopped at %0t", $time);
    endtask

    task automatic check_word(input string name, input cop_isa_pkg::cop_word_t exp,
                              input cop_isa_pkg::cop_word_t act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_result(input string name, input cop_isa_pkg::cop_result_t exp,
                                input cop_isa_pkg::cop_result_t act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t: %s expected %0d got %0d", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_gpr(input string name, input cop_isa_pkg::gpr_idx_t exp,
                             input cop_isa_pkg::gpr_idx_t act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t: %s expected %0d got %0d", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t: %s expected %b got %b", $time, name, exp, act);
            stop_run();
        end
    endtask

    // --------------------------------------------------
    // Stimulus source and model helpers
    // --------------------------------------------------
    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;                           // Callers use the high bits
    endfunction

    // One bit at a time, n steps
    function automatic cop_isa_pkg::cop_word_t rotl_model(input cop_isa_pkg::cop_word_t v,
                                                           input int n);
        cop_isa_pkg::cop_word_t r;
        r = v;
        for (int i = 0; i < n; i++) begin
            r = {r[`COP_XLEN-2:0], r[`COP_XLEN-1]};
        end
        return r;
    endfunction

    // Checker count catches up within 2 cycles of completion
    task automatic wait_checker();
        int n;
        n = 0;
        while (chk_count !== done_count && n < 2) begin
            @(negedge g_clk);
            n++;
        end
        check_word("chk_count", done_count, chk_count);
        check_bit("chk_error", 1'b0, chk_error);
    endtask

    // --------------------------------------------------
    // One instruction, request to checker update
    // --------------------------------------------------
    task automatic run_insn(input cop_isa_pkg::cop_insn_t enc, input cop_isa_pkg::cop_word_t src,
                            input logic abort, input logic [1:0] delay);
        logic [2:0]               op;
        cop_isa_pkg::cpr_idx_t    crd;
        cop_isa_pkg::cpr_idx_t    crs1;
        cop_isa_pkg::cpr_idx_t    crs2;
        cop_isa_pkg::gpr_idx_t    grd;
        cop_isa_pkg::cop_word_t   a;
        cop_isa_pkg::cop_word_t   b;
        cop_isa_pkg::cop_result_t exp_res;
        logic                     exp_wen;
        int                       n;
        op   = enc[`COP_OP_LSB +: 3];
        crd  = enc[`COP_CRD_LSB +: idx_w];
        crs1 = enc[`COP_CRS1_LSB +: idx_w];
        crs2 = enc[`COP_CRS2_LSB +: idx_w];
        grd  = enc[`COP_GRD_LSB +: $bits(cop_isa_pkg::gpr_idx_t)];
        a    = model_cprs[crs1];
        b    = model_cprs[crs2];
        exp_wen = 1'b0;
        exp_res = cop_isa_pkg::RES_OK;
        if (abort) begin
            exp_res = cop_isa_pkg::RES_ABORTED;     // No state change
        end else begin
            case (op)
                cop_isa_pkg::OP_MV2COP: model_cprs[crd] = src;
                cop_isa_pkg::OP_MV2GPR: exp_wen = 1'b1;
                cop_isa_pkg::OP_ADD:    model_cprs[crd] = a + b;
                cop_isa_pkg::OP_XOR:    model_cprs[crd] = a ^ b;
                cop_isa_pkg::OP_ROTL:   model_cprs[crd] = rotl_model(a, int'(b[4:0]));
                default:                exp_res = cop_isa_pkg::RES_BAD_INSN;
            endcase
        end
        insn_req  = 1'b1;
        insn_enc  = enc;
        rs1       = src;
        abort_req = abort;
        n = 0;
        do begin                                    // Wait for insn_ack
            @(negedge g_clk);
            n++;
            if (n > test_cycles) begin
                $display("No insn_ack for instruction %0d within %0d cycles", done_count, n);
                stop_run();
            end
        end while (insn_ack !== 1'b1);
        check_word("insn_ack latency", 1, n);
        @(negedge g_clk);                           // Accepted on the last edge
        check_bit("insn_rsp", 1'b1, insn_rsp);
        check_bit("insn_ack", 1'b0, insn_ack);
        insn_req  = 1'b0;
        abort_req = 1'b0;
        check_result("result", exp_res, result);
        check_bit("wen", exp_wen, wen);
        if (exp_wen) begin
            check_gpr("waddr", grd, waddr);
            check_word("wdata", a, wdata);
        end
        repeat (delay) begin                        // Back-pressure, outputs frozen
            @(negedge g_clk);
            check_bit("insn_rsp held", 1'b1, insn_rsp);
            check_bit("wen held", exp_wen, wen);
            check_result("result held", exp_res, result);
            if (exp_wen) begin
                check_gpr("waddr held", grd, waddr);
                check_word("wdata held", a, wdata);
            end
        end
        rsp_ack = 1'b1;
        @(negedge g_clk);
        rsp_ack = 1'b0;
        check_bit("insn_rsp after rsp_ack", 1'b0, insn_rsp);
        done_count++;
        wait_checker();
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        cop_isa_pkg::cop_insn_t enc;
        logic [31:0]            r;
        logic [31:0]            r2;
        logic                   abort;
        rng_state = seed;
        g_resetn  = 1'b0;
        insn_req  = 1'b0;
        abort_req = 1'b0;
        insn_enc  = '0;
        rs1       = '0;
        rsp_ack   = 1'b0;
        done_count = 0;
        foreach (model_cprs[i]) model_cprs[i] = '0;
        repeat (reset_cycles) @(negedge g_clk);
        g_resetn = 1'b1;
        @(negedge g_clk);
        check_bit("insn_ack after reset", 1'b0, insn_ack);
        check_bit("insn_rsp after reset", 1'b0, insn_rsp);
        check_bit("chk_error after reset", 1'b0, chk_error);
        check_word("chk_count after reset", 0, chk_count);
        for (int t = 0; t < n_tests; t++) begin
            enc = next_rand();                      // Filler for unused bits
            r   = next_rand();
            r2  = next_rand();
            enc[`COP_OP_LSB +: 3]       = r[31:29];   // Codes 5..7 are illegal
            enc[`COP_CRD_LSB +: idx_w]  = r[27:24];
            enc[`COP_CRS1_LSB +: idx_w] = r[23:20];
            enc[`COP_CRS2_LSB +: idx_w] = r[19:16];
            enc[`COP_GRD_LSB +: 5]      = r2[31:27];
            abort = ((r2 >> 16) % 32'd100) < abort_pct;
            run_insn(enc, next_rand(), abort, r2[26:25]);
        end
        // Read every CPR back through MV2GPR
        for (int i = 0; i < `COP_NCPRS; i++) begin
            enc = '0;
            enc[`COP_OP_LSB +: 3]       = cop_isa_pkg::OP_MV2GPR;
            enc[`COP_CRS1_LSB +: idx_w] = i[idx_w-1:0];
            enc[`COP_GRD_LSB +: 5]      = i[4:0];
            run_insn(enc, '0, 1'b0, 2'd0);
        end
        $display("NO ERRORS");
        $finish;
    end

    // Watchdog
    initial begin
        #(watchdog_ns);
        $display("Timeout: the tests did not finish within %0d ns", watchdog_ns);
        stop_run();
    end

endmodule

// ==== sources.f ====
+incdir+hw
hw/cop_isa_pkg.sv
hw/cop_trace_pkg.sv
hw/cop_exec.sv
hw/cop_trace_capture.sv
hw/cop_trace_checker.sv
hw/cop_checked_top.sv
test/cop_asserts.sv
test/tb_cop.sv

// ==== Makefile ====
OBJ_DIR = obj_dir
LOG     = sim.log

all: run

run:
	verilator --binary --timing --assert -f sources.f --top-module tb_cop -Mdir $(OBJ_DIR) -o tb_cop
	./$(OBJ_DIR)/tb_cop | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module tb_cop

clean:
	rm -rf $(OBJ_DIR) $(LOG)

.PHONY: all run lint clean
